// ==== flist.f ====
+incdir+include
logic/sauPkg.sv
logic/sauBitCount.sv
logic/sauShifter.sv
logic/sauExecute.sv
logic/sauResultQueue.sv
logic/sauTop.sv
test/sauTb.sv

// ==== logic/sauBitCount.sv ====
/*
 * Bit counting on a single operand
 * Leading zeros, leading ones and trailing zeros by priority scan
 * Population count by an adder tree over byte counts
 */

`timescale 1ns/10ps

module sauBitCount
	import sauPkg::*;
(
	input wordT a,
	output countT leadZeros,
	output countT leadOnes,
	output countT trailZeros,
	output countT popCount
);

	logic [3:0] byteCnt [8];
	logic [4:0] pairCnt [4];
	logic [5:0] quadCnt [2];

	// Last set bit found from the bottom is the most significant one
	function automatic countT fnLeadZeros(input wordT w);
		countT n;
		n = countT'(dataWidth);	// All-zero word
		for (int i = 0; i < dataWidth; i++)
			if (w[i])
				n = countT'(dataWidth - 1 - i);
		return n;
	endfunction

	function automatic countT fnTrailZeros(input wordT w);
		countT n;
		n = countT'(dataWidth);
		for (int i = dataWidth - 1; i >= 0; i--)
			if (w[i])
				n = countT'(i);
		return n;
	endfunction

	assign leadZeros = fnLeadZeros(a);
	assign leadOnes = fnLeadZeros(~a);	// Leading ones are leading zeros of ~a
	assign trailZeros = fnTrailZeros(a);

	// Population count tree
	always_comb
	begin
		for (int i = 0; i < 8; i++)
		begin
			byteCnt[i] = '0;
			for (int k = 0; k < 8; k++)
				byteCnt[i] = byteCnt[i] + 4'(a[8*i+k]);
		end
		for (int i = 0; i < 4; i++)
			pairCnt[i] = 5'(byteCnt[2*i]) + 5'(byteCnt[2*i+1]);
		for (int i = 0; i < 2; i++)
			quadCnt[i] = 6'(pairCnt[2*i]) + 6'(pairCnt[2*i+1]);
		popCount = countT'(quadCnt[0]) + countT'(quadCnt[1]);
	end

endmodule

// ==== logic/sauExecute.sv ====
/*
 * Execute stage of the scalar arithmetic unit
 * Opcode and function decode, raw result selection
 * Post-combine with operand c, bounds checks
 * One register stage on the outcome
 */

`timescale 1ns/10ps

module sauExecute
	import sauPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input sauReqT req,
	output logic execValid,
	output sauResT execRes
);

	countT leadZeros, leadOnes, trailZeros, popCount;
	wordT shiftLeft, shiftRightLogical, shiftRightArith, rotateLeft, rotateRight;
	wordT rawValue;
	wordT nextValue;
	causeT nextCause;
	logic combinable;	// Result goes through the post-combine
	logic isSub;
	logic geLow, gtLow, ltHigh, leHigh;
	logic chkPass;

	sauBitCount i_bitCount
	(
		.a(req.a),
		.leadZeros(leadZeros),
		.leadOnes(leadOnes),
		.trailZeros(trailZeros),
		.popCount(popCount)
	);

	sauShifter i_shifter
	(
		.a(req.a),
		.b(req.b),
		.shiftLeft(shiftLeft),
		.shiftRightLogical(shiftRightLogical),
		.shiftRightArith(shiftRightArith),
		.rotateLeft(rotateLeft),
		.rotateRight(rotateRight)
	);

	// ==========================================================
	// Unsigned bounds check
	// ==========================================================
	assign geLow = req.a >= req.b;
	assign gtLow = req.a > req.b;
	assign ltHigh = req.a < req.c;
	assign leHigh = req.a <= req.c;

	always_comb
	begin
		case (req.check)
		chkInLowLt: chkPass = geLow & ltHigh;
		chkInLowLe: chkPass = geLow & leHigh;
		chkInOpenLt: chkPass = gtLow & ltHigh;
		chkInOpenLe: chkPass = gtLow & leHigh;
		chkOutLowLt: chkPass = !(geLow & ltHigh);
		chkOutLowLe: chkPass = !(geLow & leHigh);
		chkOutOpenLt: chkPass = !(gtLow & ltHigh);
		chkOutOpenLe: chkPass = !(gtLow & leHigh);
		endcase
	end

	// ==========================================================
	// Raw result
	// ==========================================================
	always_comb
	begin
		rawValue = '0;
		nextCause = causeNone;
		combinable = 1'b0;
		case (req.opcode)
		opR3:
		begin
			combinable = 1'b1;	// Cleared below for the exceptions
			case (req.func)
			funcAdd: rawValue = req.a + req.b;
			funcSub: rawValue = req.a - req.b;
			funcAnd: rawValue = req.a & req.b;
			funcOr: rawValue = req.a | req.b;
			funcXor: rawValue = req.a ^ req.b;
			funcAsl: rawValue = shiftLeft;
			funcLsr: rawValue = shiftRightLogical;
			funcRol: rawValue = rotateLeft;
			funcRor: rawValue = rotateRight;
			funcSeq: rawValue = wordT'(req.a == req.b);
			funcSne: rawValue = wordT'(req.a != req.b);
			funcSlt: rawValue = wordT'($signed(req.a) < $signed(req.b));
			funcSle: rawValue = wordT'($signed(req.a) <= $signed(req.b));
			funcSltu: rawValue = wordT'(req.a < req.b);
			funcSleu: rawValue = wordT'(req.a <= req.b);
			funcAsr:
			begin
				rawValue = shiftRightArith;	// Combine ignored
				combinable = 1'b0;
			end
			funcMove:
			begin
				rawValue = req.b;
				combinable = 1'b0;
			end
			funcCntlz, funcCntlo, funcCnttz, funcCntpop:
			begin
				combinable = 1'b0;
				case (req.func)
				funcCntlz: rawValue = wordT'(leadZeros);
				funcCntlo: rawValue = wordT'(leadOnes);
				funcCnttz: rawValue = wordT'(trailZeros);
				default: rawValue = wordT'(popCount);
				endcase
			end
			default:
			begin
				rawValue = deadWord;
				combinable = 1'b0;
				nextCause = causeUnimp;
			end
			endcase
		end
		opAddi: rawValue = req.a + req.imm;
		opAndi: rawValue = req.a & req.imm;
		opOri: rawValue = req.a | req.imm;
		opXori: rawValue = req.a ^ req.imm;
		opSubfi: rawValue = req.imm - req.a;
		opChk:
		begin
			rawValue = '0;
			if (!chkPass)
				nextCause = causeChk;
		end
		default:
		begin
			rawValue = deadWord;	// Spare opcode encoding
			nextCause = causeUnimp;
		end
		endcase
	end

	// Post-combine with c
	assign isSub = (req.func == funcSub);

	always_comb
	begin
		nextValue = rawValue;
		if (combinable)
			case (req.combine)
			combAnd: nextValue = rawValue & req.c;
			combOr: nextValue = rawValue | req.c;
			combXor: nextValue = rawValue ^ req.c;
			combAdd: nextValue = isSub ? rawValue - req.c : rawValue + req.c;
			default: nextValue = rawValue;	// combPass and spare codes
			endcase
	end

	// ==========================================================
	// Output register
	// ==========================================================
	always_ff @(posedge clk)
	begin
		if (!rstN)
			execValid <= 1'b0;
		else
			execValid <= reqValid;
	end

	always_ff @(posedge clk)
	begin
		if (reqValid)
		begin
			execRes.value <= nextValue;
			execRes.cause <= nextCause;
		end
	end

endmodule

// ==== logic/sauPkg.sv ====
/*
 * Shared types for the scalar arithmetic unit
 * Word and count types, unimplemented-function pattern
 * Opcode, function, combine, check and cause enums
 * Request and result structs
 */

package sauPkg;

	// ==========================================================
	// Widths and constants
	// ==========================================================
	localparam int dataWidth = 64;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [$clog2(dataWidth):0] countT;	// 0 to 64 inclusive

	localparam wordT deadWord = {4{16'hdead}};

	// ==========================================================
	// Encodings
	// ==========================================================
	typedef enum logic [2:0]
	{
		opR3 = 3'd0,	// Register-register function in sauFuncT
		opAddi = 3'd1,
		opAndi = 3'd2,
		opOri = 3'd3,
		opXori = 3'd4,
		opSubfi = 3'd5,	// imm - a
		opChk = 3'd6
	} sauOpcodeT;

	typedef enum logic [4:0]
	{
		funcAdd = 5'd0,
		funcSub = 5'd1,
		funcAnd = 5'd2,
		funcOr = 5'd3,
		funcXor = 5'd4,
		funcAsl = 5'd5,
		funcLsr = 5'd6,
		funcAsr = 5'd7,
		funcRol = 5'd8,
		funcRor = 5'd9,
		funcMove = 5'd10,
		funcSeq = 5'd11,
		funcSne = 5'd12,
		funcSlt = 5'd13,
		funcSle = 5'd14,
		funcSltu = 5'd15,
		funcSleu = 5'd16,
		funcCntlz = 5'd17,
		funcCntlo = 5'd18,
		funcCnttz = 5'd19,
		funcCntpop = 5'd20
	} sauFuncT;

	typedef enum logic [2:0]
	{
		combAnd = 3'd0,
		combOr = 3'd1,
		combXor = 3'd2,
		combAdd = 3'd3,	// Becomes subtract for funcSub
		combPass = 3'd4
	} combineOpT;

	// Lower bound in b and upper bound in c, compared unsigned
	typedef enum logic [2:0]
	{
		chkInLowLt = 3'd0,	// b <= a < c
		chkInLowLe = 3'd1,	// b <= a <= c
		chkInOpenLt = 3'd2,	// b < a < c
		chkInOpenLe = 3'd3,	// b < a <= c
		chkOutLowLt = 3'd4,
		chkOutLowLe = 3'd5,
		chkOutOpenLt = 3'd6,
		chkOutOpenLe = 3'd7
	} checkCondT;

	typedef enum logic [1:0]
	{
		causeNone = 2'd0,
		causeChk = 2'd1,
		causeUnimp = 2'd2
	} causeT;

	// ==========================================================
	// Request and result
	// ==========================================================
	typedef struct packed
	{
		sauOpcodeT opcode;
		sauFuncT func;
		combineOpT combine;
		checkCondT check;
		wordT a;
		wordT b;
		wordT c;
		wordT imm;
	} sauReqT;

	typedef struct packed
	{
		wordT value;
		causeT cause;
	} sauResT;

endpackage

// ==== logic/sauResultQueue.sv ====
/*
 * Result queue
 * Circular FIFO of results with valid/ready output
 * One credit-return pulse per result removed
 */

`timescale 1ns/10ps

module sauResultQueue
	import sauPkg::*;
#(
	parameter int queueDepth = 4
)
(
	input logic clk,
	input logic rstN,
	input logic execValid,
	input sauResT execRes,
	output logic resValid,
	output sauResT res,
	input logic resReady,
	output logic creditReturn
);

	localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntWidth = $clog2(queueDepth + 1);

	sauResT entryMem [queueDepth];
	logic [ptrWidth-1:0] wrPtr, rdPtr;
	logic [cntWidth-1:0] count;	// Occupancy
	logic transfer;

	// Wraps at queueDepth, which need not be a power of two
	function automatic logic [ptrWidth-1:0] fnNextPtr(input logic [ptrWidth-1:0] p);
		if (p == ptrWidth'(queueDepth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign resValid = (count != '0);
	assign res = entryMem[rdPtr];
	assign transfer = resValid & resReady;

	// Credits guarantee a free slot on every write
	always_ff @(posedge clk)
	begin
		if (execValid)
			entryMem[wrPtr] <= execRes;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (execValid)
				wrPtr <= fnNextPtr(wrPtr);
			if (transfer)
				rdPtr <= fnNextPtr(rdPtr);
			case ({execValid, transfer})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;	// Both or neither
			endcase
			creditReturn <= transfer;	// Pulse the cycle after a pop
		end
	end

endmodule

// ==== logic/sauShifter.sv ====
/*
 * Shift and rotate unit
 * Left, logical right and arithmetic right shifts of a
 * Rotates built from the overflow half of double-width shifts
 */

`timescale 1ns/10ps

module sauShifter
	import sauPkg::*;
(
	input wordT a,
	input wordT b,
	output wordT shiftLeft,
	output wordT shiftRightLogical,
	output wordT shiftRightArith,
	output wordT rotateLeft,
	output wordT rotateRight
);

	logic [5:0] amount;
	logic [2*dataWidth-1:0] wideLeft;	// Upper half holds bits shifted out
	logic [2*dataWidth-1:0] wideRight;	// Lower half holds bits shifted out

	assign amount = b[5:0];

	assign wideLeft = {{dataWidth{1'b0}}, a} << amount;
	assign wideRight = {a, {dataWidth{1'b0}}} >> amount;

	assign shiftLeft = wideLeft[dataWidth-1:0];
	assign shiftRightLogical = wideRight[2*dataWidth-1:dataWidth];
	assign shiftRightArith = wordT'($signed(a) >>> amount);

	// Fold the overflow half back in
	assign rotateLeft = wideLeft[dataWidth-1:0] | wideLeft[2*dataWidth-1:dataWidth];
	assign rotateRight = wideRight[2*dataWidth-1:dataWidth] | wideRight[dataWidth-1:0];

endmodule

// ==== logic/sauTop.sv ====
/*
 * Top level of the scalar arithmetic unit
 * Execute stage feeding the credit-guarded result queue
 */

`timescale 1ns/10ps

module sauTop
	import sauPkg::*;
#(
	parameter int queueDepth = 4	// Also the issuer's starting credits
)
(
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input sauReqT req,
	output logic resValid,
	output sauResT res,
	input logic resReady,
	output logic creditReturn
);

	logic execValid;
	sauResT execRes;

	// ==========================================================
	// Execute stage with a fixed one-cycle latency
	// ==========================================================
	sauExecute i_execute
	(
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.execValid(execValid),
		.execRes(execRes)
	);

	// ==========================================================
	// Output queue
	// ==========================================================
	sauResultQueue #(
		.queueDepth(queueDepth)
	) i_resultQueue
	(
		.clk(clk),
		.rstN(rstN),
		.execValid(execValid),
		.execRes(execRes),
		.resValid(resValid),
		.res(res),
		.resReady(resReady),
		.creditReturn(creditReturn)
	);

endmodule

// ==== include/sauTbVectors.svh ====
/*
 * Vector table for the scalar arithmetic unit testbench
 * Each line adds one entry of test name, operands and expected result
 * Entries are issued and checked in the order listed
 */

`ifndef SAU_TB_VECTORS_SVH
`define SAU_TB_VECTORS_SVH

	task automatic loadVectors();
		wordT edgeBits;
		wordT lowByte;
		wordT ones;
		edgeBits = 64'h8000_0000_0000_0001;	// Top and bottom bit set
		lowByte = 64'h0000_0000_0000_00F0;
		ones = '1;

		// Register-register arithmetic on a=12 b=10 c=6
		addR3("add_and", funcAdd, combAnd, 12, 10, 6, 6);
		addR3("add_or", funcAdd, combOr, 12, 10, 6, 22);
		addR3("add_xor", funcAdd, combXor, 12, 10, 6, 16);
		addR3("add_add", funcAdd, combAdd, 12, 10, 6, 28);
		addR3("add_pass", funcAdd, combPass, 12, 10, 6, 22);
		addR3("sub_add", funcSub, combAdd, 12, 10, 6, 64'hFFFF_FFFF_FFFF_FFFC);	// 2 - 6
		addR3("sub_xor", funcSub, combXor, 12, 10, 6, 4);
		addR3("sub_pass", funcSub, combPass, 12, 10, 6, 2);
		addR3("and_or", funcAnd, combOr, 12, 10, 6, 14);
		addR3("or_and", funcOr, combAnd, 12, 10, 6, 6);
		addR3("or_add", funcOr, combAdd, 12, 10, 6, 20);
		addR3("xor_xor", funcXor, combXor, 12, 10, 6, 0);

		// ==========================================================
		// Shifts and rotates
		// ==========================================================
		addR3("asl_0", funcAsl, combPass, edgeBits, 0, 0, edgeBits);
		addR3("asl_low_six", funcAsl, combPass, edgeBits, 64'h144, 0, 64'h10);	// Amount 4
		addR3("asl_63", funcAsl, combPass, edgeBits, 63, 0, 64'h8000_0000_0000_0000);
		addR3("lsr_4_or", funcLsr, combOr, edgeBits, 4, 1, 64'h0800_0000_0000_0001);
		addR3("lsr_63", funcLsr, combPass, edgeBits, 63, 0, 1);
		addR3("asr_4_and", funcAsr, combAnd, edgeBits, 4, 0, 64'hF800_0000_0000_0000);
		addR3("asr_63_xor", funcAsr, combXor, edgeBits, 63, ones, ones);
		addR3("rol_4", funcRol, combPass, edgeBits, 4, 0, 64'h18);
		addR3("rol_4_add", funcRol, combAdd, edgeBits, 4, 1, 64'h19);
		addR3("ror_4", funcRor, combPass, edgeBits, 4, 0, 64'h1800_0000_0000_0000);
		addR3("ror_63", funcRor, combPass, edgeBits, 63, 0, 3);

		// Set-compares where -1 against 1 splits signed from unsigned
		addR3("seq_diff", funcSeq, combPass, ones, 1, 0, 0);
		addR3("seq_same", funcSeq, combPass, 5, 5, 0, 1);
		addR3("sne_diff", funcSne, combPass, ones, 1, 0, 1);
		addR3("sne_same", funcSne, combPass, 5, 5, 0, 0);
		addR3("slt_neg", funcSlt, combPass, ones, 1, 0, 1);
		addR3("slt_same", funcSlt, combPass, 5, 5, 0, 0);
		addR3("sle_neg", funcSle, combPass, ones, 1, 0, 1);
		addR3("sle_pos", funcSle, combPass, 1, ones, 0, 0);
		addR3("sle_same", funcSle, combPass, 5, 5, 0, 1);
		addR3("sltu_neg", funcSltu, combPass, ones, 1, 0, 0);
		addR3("sltu_pos", funcSltu, combPass, 1, ones, 0, 1);
		addR3("sleu_neg", funcSleu, combOr, ones, 1, 64'h10, 64'h10);
		addR3("sleu_same", funcSleu, combAdd, 5, 5, 2, 3);

		// Bit counts and move ignore the combine
		addR3("clz_zero", funcCntlz, combAdd, 0, 0, 100, 64);
		addR3("clz_byte", funcCntlz, combAdd, lowByte, 0, 100, 56);
		addR3("clz_ones", funcCntlz, combAdd, ones, 0, 100, 0);
		addR3("clo_ones", funcCntlo, combAdd, ones, 0, 100, 64);
		addR3("clo_top", funcCntlo, combAdd, 64'hFF00_0000_0000_0000, 0, 100, 8);
		addR3("ctz_zero", funcCnttz, combAdd, 0, 0, 100, 64);
		addR3("ctz_byte", funcCnttz, combAdd, lowByte, 0, 100, 4);
		addR3("pop_ones", funcCntpop, combAdd, ones, 0, 100, 64);
		addR3("pop_byte", funcCntpop, combAdd, lowByte, 0, 100, 4);
		addR3("move_b", funcMove, combAnd, 7, 64'h1234, 0, 64'h1234);

		// ==========================================================
		// Immediates and an unused function code
		// ==========================================================
		addImm("addi", opAddi, 64'hF0F, 64'hFF, 64'h100E);
		addImm("andi", opAndi, 64'hF0F, 64'hFF, 64'hF);
		addImm("ori", opOri, 64'hF0F, 64'hFF, 64'hFFF);
		addImm("xori", opXori, 64'hF0F, 64'hFF, 64'hFF0);
		addImm("subfi_neg", opSubfi, 64'hF0F, 64'hFF, 64'hFFFF_FFFF_FFFF_F1F0);
		addImm("subfi_pos", opSubfi, 5, 20, 15);
		addUnimplemented("unimp_25", sauFuncT'(5'd25));

		// Bounds checks against lower bound 10 and upper bound 20
		addBoundsCheck("in_low_lt_lo", chkInLowLt, 10, 1'b0);
		addBoundsCheck("in_low_lt_hi", chkInLowLt, 20, 1'b1);
		addBoundsCheck("in_low_lt_below", chkInLowLt, 5, 1'b1);
		addBoundsCheck("in_low_le_lo", chkInLowLe, 10, 1'b0);
		addBoundsCheck("in_low_le_hi", chkInLowLe, 20, 1'b0);
		addBoundsCheck("in_low_le_huge", chkInLowLe, ones, 1'b1);
		addBoundsCheck("in_open_lt_lo", chkInOpenLt, 10, 1'b1);
		addBoundsCheck("in_open_lt_mid", chkInOpenLt, 15, 1'b0);
		addBoundsCheck("in_open_lt_hi", chkInOpenLt, 20, 1'b1);
		addBoundsCheck("in_open_le_hi", chkInOpenLe, 20, 1'b0);
		addBoundsCheck("in_open_le_lo", chkInOpenLe, 10, 1'b1);
		addBoundsCheck("in_open_le_above", chkInOpenLe, 25, 1'b1);
		addBoundsCheck("out_low_lt_lo", chkOutLowLt, 10, 1'b1);
		addBoundsCheck("out_low_lt_hi", chkOutLowLt, 20, 1'b0);
		addBoundsCheck("out_low_lt_above", chkOutLowLt, 25, 1'b0);
		addBoundsCheck("out_low_le_lo", chkOutLowLe, 10, 1'b1);
		addBoundsCheck("out_low_le_hi", chkOutLowLe, 20, 1'b1);
		addBoundsCheck("out_low_le_above", chkOutLowLe, 25, 1'b0);
		addBoundsCheck("out_open_lt_lo", chkOutOpenLt, 10, 1'b0);
		addBoundsCheck("out_open_lt_mid", chkOutOpenLt, 15, 1'b1);
		addBoundsCheck("out_open_lt_hi", chkOutOpenLt, 20, 1'b0);
		addBoundsCheck("out_open_lt_below", chkOutOpenLt, 5, 1'b0);
		addBoundsCheck("out_open_le_lo", chkOutOpenLe, 10, 1'b0);
		addBoundsCheck("out_open_le_hi", chkOutOpenLe, 20, 1'b1);
		addBoundsCheck("out_open_le_below", chkOutOpenLe, 5, 1'b0);
	endtask

`endif

// ==== test/sauTb.sv ====
/*
 * Testbench for the scalar arithmetic unit
 * Credit-tracking request driver and random-ready consumer
 * Typed compare tasks against the vector table
 */

`timescale 1ns/10ps

module sauTb
	import sauPkg::*;
();

	localparam int queueDepth = 4;
	localparam int timeoutCycles = 200;	// Clock cycles allowed for each wait

	logic clk;
	logic rstN;
	logic reqValid;
	sauReqT req;
	logic resValid;
	sauResT res;
	logic resReady;
	logic creditReturn;

	int credits;	// Issuer's view of free queue slots
	int seed;

	string vecName [$];
	sauReqT vecReq [$];
	sauResT vecExp [$];

	sauTop #(
		.queueDepth(queueDepth)
	) i_dut
	(
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.resValid(resValid),
		.res(res),
		.resReady(resReady),
		.creditReturn(creditReturn)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// ==========================================================
	// Failure reporting and compares
	// ==========================================================
	task automatic stopOnFailure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic reportProblem(input string what);
		$display("ERROR %s", what);
		stopOnFailure();
	endtask

	task automatic checkValue(input string name, input wordT expected, input wordT actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkCause(input string name, input causeT expected, input causeT actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s cause expected %0d actual %0d", name, expected, actual);
			stopOnFailure();
		end
	endtask

	// ==========================================================
	// Table building
	// ==========================================================
	task automatic pushVector(input string name, input sauReqT r, input sauResT exp);
		vecName.push_back(name);
		vecReq.push_back(r);
		vecExp.push_back(exp);
	endtask

	task automatic addR3(input string name, input sauFuncT func, input combineOpT comb,
		input wordT a, input wordT b, input wordT c, input wordT expValue);
		sauReqT r;
		sauResT exp;
		r = '0;
		r.opcode = opR3;
		r.func = func;
		r.combine = comb;
		r.a = a;
		r.b = b;
		r.c = c;
		exp.value = expValue;
		exp.cause = causeNone;
		pushVector(name, r, exp);
	endtask

	task automatic addImm(input string name, input sauOpcodeT op, input wordT a,
		input wordT imm, input wordT expValue);
		sauReqT r;
		sauResT exp;
		r = '0;
		r.opcode = op;
		r.combine = combOr;	// Immediates skip the combine
		r.c = 64'h7;
		r.a = a;
		r.imm = imm;
		exp.value = expValue;
		exp.cause = causeNone;
		pushVector(name, r, exp);
	endtask

	task automatic addUnimplemented(input string name, input sauFuncT code);
		sauReqT r;
		sauResT exp;
		r = '0;
		r.opcode = opR3;
		r.func = code;
		r.a = 3;
		r.b = 4;
		exp.value = 64'hDEAD_DEAD_DEAD_DEAD;
		exp.cause = causeUnimp;
		pushVector(name, r, exp);
	endtask

	task automatic addBoundsCheck(input string name, input checkCondT cond, input wordT a,
		input bit fault);
		sauReqT r;
		sauResT exp;
		r = '0;
		r.opcode = opChk;
		r.check = cond;
		r.a = a;
		r.b = 10;
		r.c = 20;
		exp.value = '0;
		exp.cause = fault ? causeChk : causeNone;
		pushVector(name, r, exp);
	endtask

	`include "sauTbVectors.svh"

	// ==========================================================
	// Driver and consumer
	// ==========================================================
	// A credit is spent when reqValid goes up and comes back on each creditReturn pulse
	task automatic issueRequests();
		int next;
		int idle;
		next = 0;
		idle = 0;
		while (next < vecName.size() || credits != queueDepth)
		begin
			@(posedge clk);
			if (creditReturn)
				credits++;
			if (credits > queueDepth)
				reportProblem("credit count rose above queueDepth");
			if (next < vecName.size() && credits > 0)
			begin
				reqValid <= 1'b1;
				req <= vecReq[next];
				credits--;
				next++;
				idle = 0;
			end
			else
			begin
				reqValid <= 1'b0;
				idle++;
				if (idle > timeoutCycles && next < vecName.size())
					reportProblem("timed out waiting for a credit to issue a request");
				else if (idle > timeoutCycles)
					reportProblem("timed out waiting for all credits to return");
			end
		end
		reqValid <= 1'b0;
	endtask

	task automatic consumeResults();
		int got;
		int waited;
		got = 0;
		waited = 0;
		while (got < vecName.size())
		begin
			@(posedge clk);
			if (resValid && resReady)	// Transfer at this edge
			begin
				checkValue(vecName[got], vecExp[got].value, res.value);
				checkCause(vecName[got], vecExp[got].cause, res.cause);
				got++;
				waited = 0;
			end
			else
			begin
				waited++;
				if (waited > timeoutCycles)
					reportProblem("timed out waiting for a result");
			end
			resReady <= (($random(seed) % 2) != 0);
		end
		resReady <= 1'b0;
	endtask

	initial
	begin
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		resReady = 1'b0;
		credits = queueDepth;
		seed = 32'h4cbf;
		loadVectors();
		repeat (4)
			@(posedge clk);
		rstN <= 1'b1;
		fork
			issueRequests();
			consumeResults();
		join
		if (resValid)
			reportProblem("an extra result appeared after the last expected one");
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule
